// File: filelist.f
soc_pkg.sv
io_pad_ring.sv
bus_arbiter.sv
host_port.sv
irq_responder.sv
gpio_regs.sv
soc_top.sv
chip_top.sv
tb_chip_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the chip testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns --top-module tb_chip_top \
  -f filelist.f -o sim_chip
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_chip)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^Everything OK$"; then
  exit 0
fi
exit 1

// File: tb_chip_top.sv
`timescale 1ns/1ns

module tb_chip_top import soc_pkg::*; ();

  localparam int unsigned GpioCount  = 16;
  localparam int          CycleLimit = 2000; // Several times the length of all tests.

  logic                 clk;
  logic                 rst;
  logic                 irq0;
  logic [GpioCount-1:0] gpio_in;
  logic                 host_req;
  bus_req_t             host_cmd;
  logic                 status;
  logic [GpioCount-1:0] gpio_out;
  logic [GpioCount-1:0] gpio_oe;
  logic                 host_busy;
  logic                 host_done;
  logic [DataWidth-1:0] host_rdata;

  logic [31:0]          lcg_state;
  int                   cycle_count = 0;

  // Expected register contents.
  logic [GpioCount-1:0] exp_out;
  logic [GpioCount-1:0] exp_oe;
  logic [GpioCount-1:0] exp_snap;
  logic                 exp_status;
  logic [7:0]           exp_cnt;

  chip_top #(
    .GpioCount ( GpioCount )
  ) DUT (
    .clk_i        ( clk        ),
    .rst_i        ( rst        ),
    .irq0_i       ( irq0       ),
    .status_o     ( status     ),
    .gpio_i       ( gpio_in    ),
    .gpio_o       ( gpio_out   ),
    .gpio_oe_o    ( gpio_oe    ),
    .host_req_i   ( host_req   ),
    .host_cmd_i   ( host_cmd   ),
    .host_busy_o  ( host_busy  ),
    .host_done_o  ( host_done  ),
    .host_rdata_o ( host_rdata )
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CycleLimit) begin
      $display("timeout: the tests did not finish within %0d cycles", CycleLimit);
      $display("Something failed");
      $fatal(1, "run stopped at the cycle limit");
    end
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_data(input string what, input logic [DataWidth-1:0] got,
                            input logic [DataWidth-1:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
      $display("Something failed");
      $fatal(1, "data check failed");
    end
  endtask

  task automatic check_gpio(input string what, input logic [GpioCount-1:0] got,
                            input logic [GpioCount-1:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
      $display("Something failed");
      $fatal(1, "pin check failed");
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %b, expected %b", $time, what, got, exp);
      $display("Something failed");
      $fatal(1, "bit check failed");
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Expected read data of a register.
  function automatic logic [DataWidth-1:0] model_value(input reg_addr_e addr);
    logic [DataWidth-1:0] value;
    value = '0;
    case (addr)
      REG_OUT:     value[GpioCount-1:0] = exp_out;
      REG_OE:      value[GpioCount-1:0] = exp_oe;
      REG_IN:      value[GpioCount-1:0] = gpio_in;
      REG_STATUS:  value[0] = exp_status;
      REG_SNAP:    value[GpioCount-1:0] = exp_snap;
      REG_IRQ_CNT: value[7:0] = exp_cnt;
      default:     value = '0;
    endcase
    return value;
  endfunction

  // Starts and ends on a falling edge; returns in the done cycle.
  task automatic host_access(input bus_req_t cmd, output logic [DataWidth-1:0] rdata);
    host_req = 1'b1;
    host_cmd = cmd;
    @(negedge clk);
    host_req = 1'b0;
    check_bit("host_busy_o after strobe", host_busy, 1'b1);
    while (!host_done) @(negedge clk);
    check_bit("host_busy_o at done", host_busy, 1'b0);
    rdata = host_rdata;
  endtask

  task automatic host_write(input reg_addr_e addr, input logic [DataWidth-1:0] data);
    bus_req_t             cmd;
    logic [DataWidth-1:0] unused;
    cmd = '{addr: addr, we: 1'b1, wdata: data};
    host_access(cmd, unused);
  endtask

  task automatic host_read(input reg_addr_e addr, output logic [DataWidth-1:0] data);
    bus_req_t cmd;
    cmd = '{addr: addr, we: 1'b0, wdata: '0};
    host_access(cmd, data);
  endtask

  task automatic reg_write(input reg_addr_e addr, input logic [DataWidth-1:0] data);
    host_write(addr, data);
    case (addr)
      REG_OUT:     exp_out = data[GpioCount-1:0];
      REG_OE:      exp_oe = data[GpioCount-1:0];
      REG_STATUS:  exp_status = data[0];
      REG_SNAP:    exp_snap = data[GpioCount-1:0];
      REG_IRQ_CNT: exp_cnt = exp_cnt + 8'd1; // Any write counts.
      default: ;
    endcase
  endtask

  task automatic reset_values();
    check_gpio("gpio_o after reset", gpio_out, '0);
    check_gpio("gpio_oe_o after reset", gpio_oe, '0);
    check_bit("status_o after reset", status, 1'b0);
    check_bit("host_busy_o after reset", host_busy, 1'b0);
  endtask

  task automatic output_loopback(input int rounds);
    logic [DataWidth-1:0] data;
    for (int i = 0; i < rounds; i++) begin
      reg_write(REG_OUT, next_random());
      reg_write(REG_OE, next_random());
      wait_cycles(1);
      check_gpio("gpio_o", gpio_out, exp_out);
      check_gpio("gpio_oe_o", gpio_oe, exp_oe);
      host_read(REG_OUT, data);
      check_data("REG_OUT read", data, model_value(REG_OUT));
      host_read(REG_OE, data);
      check_data("REG_OE read", data, model_value(REG_OE));
    end
  endtask

  task automatic input_sampling(input int rounds);
    logic [DataWidth-1:0] data;
    for (int i = 0; i < rounds; i++) begin
      gpio_in = GpioCount'(next_random() >> 8);
      wait_cycles(3); // Two synchronizer stages and a margin.
      host_read(REG_IN, data);
      check_data("REG_IN read", data, model_value(REG_IN));
    end
  endtask

  task automatic status_and_holes();
    logic [DataWidth-1:0] data;
    reg_write(REG_STATUS, next_random() | 32'd1);
    wait_cycles(1);
    check_bit("status_o set", status, exp_status);
    reg_write(REG_STATUS, next_random() & ~32'd1);
    wait_cycles(1);
    check_bit("status_o clear", status, exp_status);
    host_read(REG_STATUS, data);
    check_data("REG_STATUS read", data, model_value(REG_STATUS));
    host_read(reg_addr_e'(4'd9), data);
    check_data("undefined address read", data, '0);
  endtask

  task automatic snapshot_on_irq();
    logic [DataWidth-1:0] data;
    host_read(REG_IRQ_CNT, data);
    check_data("count before irq", data, model_value(REG_IRQ_CNT));
    gpio_in = GpioCount'(next_random() >> 12);
    wait_cycles(3);
    irq0 = 1'b1;
    wait_cycles(3);
    irq0 = 1'b0;
    wait_cycles(20);
    exp_snap = gpio_in;
    exp_cnt  = exp_cnt + 8'd1;
    host_read(REG_SNAP, data);
    check_data("REG_SNAP after irq", data, model_value(REG_SNAP));
    host_read(REG_IRQ_CNT, data);
    check_data("REG_IRQ_CNT after irq", data, model_value(REG_IRQ_CNT));
  endtask

  task automatic host_traffic(input int count);
    reg_addr_e            addr;
    logic [DataWidth-1:0] data;
    for (int i = 0; i < count; i++) begin
      case (next_random() % 32'd3)
        32'd0:   addr = REG_OUT;
        32'd1:   addr = REG_OE;
        default: addr = REG_STATUS;
      endcase
      reg_write(addr, next_random());
      host_read(addr, data);
      check_data("read under irq traffic", data, model_value(addr));
    end
  endtask

  // Spacing leaves the responder idle before each new edge.
  task automatic irq_pulses(input int count);
    for (int i = 0; i < count; i++) begin
      irq0 = 1'b1;
      wait_cycles(2);
      irq0 = 1'b0;
      wait_cycles(22);
    end
  endtask

  task automatic irq_under_traffic();
    logic [DataWidth-1:0] data;
    gpio_in = GpioCount'(next_random());
    wait_cycles(3);
    fork
      host_traffic(12);
      irq_pulses(3);
    join
    wait_cycles(20);
    exp_snap = gpio_in;
    exp_cnt  = exp_cnt + 8'd3;
    host_read(REG_IRQ_CNT, data);
    check_data("REG_IRQ_CNT after traffic", data, model_value(REG_IRQ_CNT));
    host_read(REG_SNAP, data);
    check_data("REG_SNAP after traffic", data, model_value(REG_SNAP));
  endtask

  initial begin
    lcg_state  = 32'd76;
    rst        = 1'b1;
    irq0       = 1'b0;
    gpio_in    = '0;
    host_req   = 1'b0;
    host_cmd   = '0;
    exp_out    = '0;
    exp_oe     = '0;
    exp_snap   = '0;
    exp_status = 1'b0;
    exp_cnt    = '0;
    wait_cycles(5);
    rst = 1'b0;
    reset_values();
    output_loopback(4);
    input_sampling(3);
    status_and_holes();
    snapshot_on_irq();
    irq_under_traffic();
    $display("Everything OK");
    $finish;
  end

endmodule

// File: chip_top.sv
`timescale 1ns/1ns

module chip_top import soc_pkg::*; #(
  parameter int unsigned GpioCount = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 irq0_i,
  output logic                 status_o,
  input  logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_oe_o,
  input  logic                 host_req_i,
  input  bus_req_t             host_cmd_i,
  output logic                 host_busy_o,
  output logic                 host_done_o,
  output logic [DataWidth-1:0] host_rdata_o
);

  logic [GpioCount-1:0] soc_gpio_in;
  logic [GpioCount-1:0] soc_gpio_out;
  logic [GpioCount-1:0] soc_gpio_oe; // 1 drives the pin.
  logic                 soc_irq;
  logic                 soc_status;

  io_pad_ring #(
    .GpioCount ( GpioCount )
  ) i_io_pad_ring (
    .clk_i         ( clk_i        ),
    .rst_i         ( rst_i        ),
    .gpio_i        ( gpio_i       ),
    .irq0_i        ( irq0_i       ),
    .core_gpio_o   ( soc_gpio_in  ),
    .core_irq_o    ( soc_irq      ),
    .core_gpio_i   ( soc_gpio_out ),
    .core_oe_i     ( soc_gpio_oe  ),
    .core_status_i ( soc_status   ),
    .gpio_o        ( gpio_o       ),
    .gpio_oe_o     ( gpio_oe_o    ),
    .status_o      ( status_o     )
  );

  // Host command port goes straight to the core.
  soc_top #(
    .GpioCount ( GpioCount )
  ) i_soc_top (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .irq_i        ( soc_irq      ),
    .host_req_i   ( host_req_i   ),
    .host_cmd_i   ( host_cmd_i   ),
    .host_busy_o  ( host_busy_o  ),
    .host_done_o  ( host_done_o  ),
    .host_rdata_o ( host_rdata_o ),
    .gpio_in_i    ( soc_gpio_in  ),
    .gpio_out_o   ( soc_gpio_out ),
    .gpio_oe_o    ( soc_gpio_oe  ),
    .status_o     ( soc_status   )
  );

endmodule

// File: soc_top.sv
`timescale 1ns/1ns

module soc_top import soc_pkg::*; #(
  parameter int unsigned GpioCount = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 irq_i,
  input  logic                 host_req_i,
  input  bus_req_t             host_cmd_i,
  output logic                 host_busy_o,
  output logic                 host_done_o,
  output logic [DataWidth-1:0] host_rdata_o,
  input  logic [GpioCount-1:0] gpio_in_i,
  output logic [GpioCount-1:0] gpio_out_o,
  output logic [GpioCount-1:0] gpio_oe_o,
  output logic                 status_o
);

  // Master 0 is the host port, master 1 the interrupt responder.
  logic [1:0] m_req;
  bus_req_t   m_req_data [2];
  logic [1:0] m_gnt;
  bus_rsp_t   m_rsp [2];
  logic       sel;
  bus_req_t   bus_req;
  bus_rsp_t   bus_rsp;

  host_port i_host_port (
    .clk_i        ( clk_i         ),
    .rst_i        ( rst_i         ),
    .host_req_i   ( host_req_i    ),
    .host_cmd_i   ( host_cmd_i    ),
    .host_busy_o  ( host_busy_o   ),
    .host_done_o  ( host_done_o   ),
    .host_rdata_o ( host_rdata_o  ),
    .req_o        ( m_req[0]      ),
    .req_data_o   ( m_req_data[0] ),
    .gnt_i        ( m_gnt[0]      ),
    .rsp_i        ( m_rsp[0]      )
  );

  irq_responder i_irq_responder (
    .clk_i      ( clk_i         ),
    .rst_i      ( rst_i         ),
    .irq_i      ( irq_i         ),
    .req_o      ( m_req[1]      ),
    .req_data_o ( m_req_data[1] ),
    .gnt_i      ( m_gnt[1]      ),
    .rsp_i      ( m_rsp[1]      )
  );

  bus_arbiter i_bus_arbiter (
    .clk_i      ( clk_i      ),
    .rst_i      ( rst_i      ),
    .req_i      ( m_req      ),
    .req_data_i ( m_req_data ),
    .gnt_o      ( m_gnt      ),
    .sel_o      ( sel        ),
    .bus_req_o  ( bus_req    ),
    .bus_rsp_i  ( bus_rsp    ),
    .rsp_o      ( m_rsp      )
  );

  gpio_regs #(
    .GpioCount ( GpioCount )
  ) i_gpio_regs (
    .clk_i      ( clk_i      ),
    .rst_i      ( rst_i      ),
    .sel_i      ( sel        ),
    .bus_req_i  ( bus_req    ),
    .bus_rsp_o  ( bus_rsp    ),
    .gpio_in_i  ( gpio_in_i  ),
    .gpio_out_o ( gpio_out_o ),
    .gpio_oe_o  ( gpio_oe_o  ),
    .status_o   ( status_o   )
  );

endmodule

// File: gpio_regs.sv
`timescale 1ns/1ns

module gpio_regs import soc_pkg::*; #(
  parameter int unsigned GpioCount = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 sel_i,
  input  bus_req_t             bus_req_i,
  output bus_rsp_t             bus_rsp_o,
  input  logic [GpioCount-1:0] gpio_in_i,
  output logic [GpioCount-1:0] gpio_out_o,
  output logic [GpioCount-1:0] gpio_oe_o,
  output logic                 status_o
);

  logic [GpioCount-1:0] out_q;
  logic [GpioCount-1:0] oe_q;
  logic [GpioCount-1:0] snap_q;
  logic                 status_q;
  logic [7:0]           cnt_q;
  logic                 wr_en;
  logic [DataWidth-1:0] rdata;
  logic                 rvalid_q;
  logic [DataWidth-1:0] rdata_q;

  assign wr_en = sel_i && bus_req_i.we;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_q    <= '0;
      oe_q     <= '0;
      snap_q   <= '0;
      status_q <= 1'b0;
      cnt_q    <= '0;
    end else if (wr_en) begin
      case (bus_req_i.addr)
        REG_OUT:     out_q    <= bus_req_i.wdata[GpioCount-1:0];
        REG_OE:      oe_q     <= bus_req_i.wdata[GpioCount-1:0];
        REG_STATUS:  status_q <= bus_req_i.wdata[0];
        REG_SNAP:    snap_q   <= bus_req_i.wdata[GpioCount-1:0];
        REG_IRQ_CNT: cnt_q    <= cnt_q + 8'd1; // Write data is ignored.
        default: ;                             // REG_IN and holes are read-only.
      endcase
    end
  end

  // Read data is zero-extended.
  always_comb begin
    rdata = '0;
    case (bus_req_i.addr)
      REG_OUT:     rdata[GpioCount-1:0] = out_q;
      REG_OE:      rdata[GpioCount-1:0] = oe_q;
      REG_IN:      rdata[GpioCount-1:0] = gpio_in_i;
      REG_STATUS:  rdata[0]             = status_q;
      REG_SNAP:    rdata[GpioCount-1:0] = snap_q;
      REG_IRQ_CNT: rdata[7:0]           = cnt_q;
      default:     rdata                = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= sel_i; // Answer one cycle after select.
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_i) rdata_q <= rdata;
  end

  assign bus_rsp_o  = '{rvalid: rvalid_q, rdata: rdata_q};
  assign gpio_out_o = out_q;
  assign gpio_oe_o  = oe_q;
  assign status_o   = status_q;

endmodule

// File: irq_responder.sv
`timescale 1ns/1ns

module irq_responder import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     irq_i,
  output logic     req_o,
  output bus_req_t req_data_o,
  input  logic     gnt_i,
  input  bus_rsp_t rsp_i
);

  resp_state_e state_q;
  bus_req_t    req_q;
  logic        irq_q;
  logic        irq_edge;

  assign irq_edge = irq_i && !irq_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= RESP_IDLE;
      irq_q   <= 1'b0;
      req_q   <= '{addr: REG_IN, we: 1'b0, wdata: '0};
    end else begin
      irq_q <= irq_i;
      case (state_q)
        RESP_IDLE: begin
          if (irq_edge) begin // Edges seen in other states are dropped.
            state_q <= RESP_READ;
            req_q   <= '{addr: REG_IN, we: 1'b0, wdata: '0};
          end
        end
        RESP_READ, RESP_WRITE, RESP_COUNT: begin
          if (gnt_i) state_q <= RESP_WAIT;
        end
        RESP_WAIT: begin
          // The address of the finished access selects the next step
          if (rsp_i.rvalid) begin
            case (req_q.addr)
              REG_IN: begin
                state_q <= RESP_WRITE;
                req_q   <= '{addr: REG_SNAP, we: 1'b1, wdata: rsp_i.rdata};
              end
              REG_SNAP: begin
                state_q <= RESP_COUNT;
                req_q   <= '{addr: REG_IRQ_CNT, we: 1'b1, wdata: '0}; // Any write increments.
              end
              default: state_q <= RESP_IDLE;
            endcase
          end
        end
        default: state_q <= RESP_IDLE;
      endcase
    end
  end

  assign req_o      = state_q inside {RESP_READ, RESP_WRITE, RESP_COUNT};
  assign req_data_o = req_q;

endmodule

// File: host_port.sv
`timescale 1ns/1ns

module host_port import soc_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 host_req_i,
  input  bus_req_t             host_cmd_i,
  output logic                 host_busy_o,
  output logic                 host_done_o,
  output logic [DataWidth-1:0] host_rdata_o,
  output logic                 req_o,
  output bus_req_t             req_data_o,
  input  logic                 gnt_i,
  input  bus_rsp_t             rsp_i
);

  logic                 busy_q;
  logic                 req_q;
  logic                 done_q;
  logic                 accept;
  logic                 finish;
  bus_req_t             cmd_q;
  logic [DataWidth-1:0] rdata_q;

  assign accept = !busy_q && host_req_i; // Strobes while busy are ignored.
  assign finish = busy_q && !req_q && rsp_i.rvalid;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      req_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= finish;
      if (accept) begin
        busy_q <= 1'b1;
        req_q  <= 1'b1;
      end else if (req_q && gnt_i) begin
        req_q  <= 1'b0;
      end else if (finish) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) cmd_q <= host_cmd_i;
    if (finish) rdata_q <= rsp_i.rdata;
  end

  assign req_o        = req_q;
  assign req_data_o   = cmd_q;
  assign host_busy_o  = busy_q;
  assign host_done_o  = done_q;
  assign host_rdata_o = rdata_q;

endmodule

// File: bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter import soc_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic [1:0] req_i,
  input  bus_req_t   req_data_i [2],
  output logic [1:0] gnt_o,
  output logic       sel_o,
  output bus_req_t   bus_req_o,
  input  bus_rsp_t   bus_rsp_i,
  output bus_rsp_t   rsp_o [2]
);

  logic prio_q;  // Master that wins a tie.
  logic owner_q; // Master granted in the previous cycle.
  logic winner;

  // With a single requester it wins, otherwise the priority bit decides.
  always_comb begin
    if (req_i[0] && req_i[1]) begin
      winner = prio_q;
    end else begin
      winner = req_i[1];
    end
  end

  assign sel_o     = |req_i;
  assign bus_req_o = req_data_i[winner];
  assign gnt_o[0]  = sel_o && !winner;
  assign gnt_o[1]  = sel_o && winner;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prio_q  <= 1'b0; // Host first.
      owner_q <= 1'b0;
    end else if (sel_o) begin
      prio_q  <= ~winner;
      owner_q <= winner;
    end
  end

  // The slave answers one cycle after sel, so route by owner.
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      rsp_o[i].rdata  = bus_rsp_i.rdata;
      rsp_o[i].rvalid = bus_rsp_i.rvalid && (owner_q == 1'(i));
    end
  end

endmodule

// File: io_pad_ring.sv
`timescale 1ns/1ns

module io_pad_ring #(
  parameter int unsigned GpioCount = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic [GpioCount-1:0] gpio_i,
  input  logic                 irq0_i,
  output logic [GpioCount-1:0] core_gpio_o,
  output logic                 core_irq_o,
  input  logic [GpioCount-1:0] core_gpio_i,
  input  logic [GpioCount-1:0] core_oe_i,
  input  logic                 core_status_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_oe_o,
  output logic                 status_o
);

  // Top bit carries the interrupt pin.
  logic [GpioCount:0] sync1_q;
  logic [GpioCount:0] sync2_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync1_q   <= '0;
      sync2_q   <= '0;
      gpio_o    <= '0;
      gpio_oe_o <= '0;
      status_o  <= 1'b0;
    end else begin
      sync1_q   <= {irq0_i, gpio_i};
      sync2_q   <= sync1_q;
      gpio_o    <= core_gpio_i; // Output pads are registered.
      gpio_oe_o <= core_oe_i;
      status_o  <= core_status_i;
    end
  end

  assign core_gpio_o = sync2_q[GpioCount-1:0];
  assign core_irq_o  = sync2_q[GpioCount];

endmodule

// File: soc_pkg.sv
package soc_pkg;

  localparam int unsigned AddrWidth = 4;
  localparam int unsigned DataWidth = 32;

  // Register map of the GPIO block.
  typedef enum logic [AddrWidth-1:0] {
    REG_OUT     = 4'd0,
    REG_OE      = 4'd1,
    REG_IN      = 4'd2,
    REG_STATUS  = 4'd3,
    REG_SNAP    = 4'd4,
    REG_IRQ_CNT = 4'd5
  } reg_addr_e;

  typedef struct packed {
    reg_addr_e            addr;
    logic                 we;
    logic [DataWidth-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic                 rvalid;
    logic [DataWidth-1:0] rdata;
  } bus_rsp_t;

  typedef enum logic [2:0] {
    RESP_IDLE,
    RESP_READ,  // Requesting the REG_IN read.
    RESP_WAIT,  // Waiting for the response of the last access.
    RESP_WRITE, // Requesting the snapshot write.
    RESP_COUNT  // Requesting the count increment.
  } resp_state_e;

endpackage
